//--- testbench/rom_cases.txt
// columns: op, byte address, byte (all hex)
// op 1 load, op 2 read and expect byte, op 3 load above the ROM size
1 0000 3c
1 0001 a5
1 0002 7e
1 0003 01
1 0004 c3
1 0005 5a
1 0011 e7
1 0010 18
2 0000 3c
2 0001 a5
2 0003 01
2 0002 7e
2 0005 5a
2 0004 c3
2 0010 18
2 0011 e7
1 0001 96
1 0004 0f
2 0000 3c
2 0001 96
2 0004 0f
2 0005 5a
3 8000 ff
3 8001 ee
3 8011 dd
3 c004 cc
2 0000 3c
2 0001 96
2 0011 e7
2 0004 0f

//--- build.f
design/arcade_pkg.sv
design/ce_gen.sv
design/rom_loader.sv
design/rom_store.sv
design/rom_fetch.sv
design/arcade_rom_top.sv
testbench/tb_arcade_rom_assert.sv
testbench/tb_arcade_rom.sv

//--- Makefile
TOP = tb_arcade_rom

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

# pass only if the testbench printed its pass line
run: build
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- testbench/tb_arcade_rom.sv
// Testbench for the ROM download and CPU fetch subsystem.
// Replays testbench/rom_cases.txt (path from the project root), then fills
// 256 bytes with xorshift data and checks bursts, blocked fetches and loads
// above the ROM size against a byte model.
// Only bytes that were loaded are ever read back.

`timescale 1ns/1ps

module tb_arcade_rom import arcade_pkg::*; ();

	localparam int          ROM_ADDR_W   = 15;
	localparam int          CE179_DIV    = 14;
	localparam int          ROM_BYTES    = 1 << ROM_ADDR_W;
	localparam int          MAX_CASES    = 64;
	localparam int          READ_TIMEOUT = 16;
	localparam logic [14:0] FILL_BASE    = 15'h1000;

	logic                  clk_sys;
	logic                  arst_n;
	logic                  user_reset;
	logic                  dl_active;
	logic                  dl_wr;
	dl_byte_t              dl_byte;
	logic                  cpu_rd;
	logic [ROM_ADDR_W-1:0] cpu_addr;
	logic [7:0]            rom_data;
	logic                  rom_valid;
	logic                  game_reset;
	logic                  download_done;
	ce_bus_t               ce;

	logic [15:0] case_mem [0:3*MAX_CASES-1];
	logic [7:0]  model [0:ROM_BYTES-1];
	logic        known [0:ROM_BYTES-1];
	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          test_errors;

	arcade_rom_top #(.ROM_ADDR_W(ROM_ADDR_W), .CE179_DIV(CE179_DIV)) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// helpers
	// ========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic compare_count(input string name, input int exp, input int got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("MISMATCH t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
		end
	endtask

	task automatic check_condition(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR t=%0t %s", $time, msg);
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
		end
		$display("test %-16s %s", name, (errors == test_errors) ? "ok" : "FAILED");
	endtask

	task automatic open_download();
		dl_active = 1'b1;
		repeat (2) step();
	endtask

	task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
		dl_byte = '{addr: addr, data: data};
		dl_wr   = 1'b1;
		step();
		dl_wr   = 1'b0;
		step();
		if (int'(addr) < ROM_BYTES) begin
			model[addr[14:0]] = data;
			known[addr[14:0]] = 1'b1;
		end
	endtask

	// done must pulse once in the window after dl_active falls
	task automatic close_download();
		int n;
		int pulses;
		pulses    = 0;
		dl_active = 1'b0;
		for (n = 0; n < 6; n++) begin
			step();
			if (download_done) pulses++;
		end
		compare_count("download_done pulses", 1, pulses);
	endtask

	task automatic check_read(input logic [14:0] addr, input logic [7:0] exp);
		int lat;
		cpu_rd   = 1'b1;
		cpu_addr = addr;
		step();
		cpu_rd = 1'b0;
		lat    = 1;
		while (!rom_valid && lat < READ_TIMEOUT) begin
			step();
			lat++;
		end
		check_condition(rom_valid, $sformatf("no rom_valid after a fetch at %h", addr));
		if (rom_valid) begin
			compare_count("read latency", 2, lat);
			compare_count($sformatf("rom_data[%h]", addr), exp, rom_data);
		end
	endtask

	// four fetches, then four quiet cycles, all counted
	// game_reset stays high throughout
	task automatic blocked_fetches(output int valids);
		int n;
		valids = 0;
		for (n = 0; n < 8; n++) begin
			cpu_rd   = (n < 4);
			cpu_addr = ROM_ADDR_W'(n);
			step();
			compare_count("game_reset", 1, game_reset);
			if (rom_valid) valids++;
		end
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		int          idx;
		int          n;
		int          valids;
		int          ce_cnt [4];
		logic        in_dl;
		logic [15:0] op;
		logic [15:0] addr;
		logic [7:0]  dat;
		logic [31:0] rnd;
		logic [14:0] raddr;
		logic [7:0]  exp_q [$];

		arst_n     = 1'b0;
		user_reset = 1'b0;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_byte    = '0;
		cpu_rd     = 1'b0;
		cpu_addr   = '0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rng_state    = 32'h6f33_40ca;
		for (idx = 0; idx < 3 * MAX_CASES; idx++) case_mem[idx] = '0;
		for (idx = 0; idx < ROM_BYTES; idx++) known[idx] = 1'b0;
		$readmemh("testbench/rom_cases.txt", case_mem);

		// outputs sampled while the reset is still applied
		start_test();
		repeat (3) step();
		compare_count("rom_valid", 0, rom_valid);
		compare_count("download_done", 0, download_done);
		compare_count("ce", 0, ce);
		compare_count("game_reset", 0, game_reset);
		arst_n = 1'b1;
		step();
		finish_test("reset_values");

		start_test();
		ce_cnt = '{default: 0};
		for (n = 0; n < 56; n++) begin
			step();
			ce_cnt[0] += int'(ce.ce_12);
			ce_cnt[1] += int'(ce.ce_6p);
			ce_cnt[2] += int'(ce.ce_6n);
			ce_cnt[3] += int'(ce.ce_1p79);
		end
		compare_count("ce_12 pulses", 28, ce_cnt[0]);
		compare_count("ce_6p pulses", 14, ce_cnt[1]);
		compare_count("ce_6n pulses", 14, ce_cnt[2]);
		compare_count("ce_1p79 pulses", 4, ce_cnt[3]);
		finish_test("ce_counts");

		// loads open a download, the next read closes it
		start_test();
		in_dl = 1'b0;
		for (idx = 0; idx < MAX_CASES && case_mem[3*idx] != 16'd0; idx++) begin
			op   = case_mem[3*idx];
			addr = case_mem[3*idx+1];
			dat  = case_mem[3*idx+2][7:0];
			if (op == 16'd2) begin
				if (in_dl) close_download();
				in_dl = 1'b0;
				check_read(addr[14:0], dat);
			end else begin
				check_condition(op == 16'd1 || (op == 16'd3 && int'(addr) >= ROM_BYTES),
					$sformatf("case %0d has a bad op or address", idx));
				if (!in_dl) open_download();
				in_dl = 1'b1;
				load_byte(addr, dat);
			end
		end
		if (in_dl) close_download();
		check_condition(idx > 0, "case file holds no cases");
		finish_test("case_file");

		start_test();
		open_download();
		for (n = 0; n < 256; n++) begin
			rnd = next_random();
			load_byte(16'(FILL_BASE) + 16'(n), rnd[7:0]);
		end
		close_download();
		valids = 0;
		for (n = 0; n < 72; n++) begin
			cpu_rd = (n < 64);
			if (n < 64) begin
				rnd      = next_random();
				raddr    = FILL_BASE + 15'(rnd[7:0]);
				cpu_addr = raddr;
				exp_q.push_back(model[raddr]);
			end
			step();
			if (rom_valid) begin
				valids++;
				check_condition(exp_q.size() != 0, "rom_valid with no fetch outstanding");
				if (exp_q.size() != 0) compare_count("rom_data", exp_q.pop_front(), rom_data);
			end
		end
		compare_count("rom_valid pulses", 64, valids);
		finish_test("fetch_burst");

		start_test();
		open_download();
		blocked_fetches(valids);
		compare_count("rom_valid during download", 0, valids);
		close_download();
		compare_count("game_reset after download", 0, game_reset);
		user_reset = 1'b1;
		blocked_fetches(valids);
		compare_count("rom_valid during user_reset", 0, valids);
		user_reset = 1'b0;
		check_read(15'h0, model[0]);
		finish_test("blocked_fetch");

		// half alias the low bytes, half the fill bytes read back below
		start_test();
		open_download();
		for (n = 0; n < 16; n++) begin
			rnd  = next_random();
			addr = (n < 8) ? 16'(n) : 16'(FILL_BASE + 15'((n - 8) * 31));
			load_byte(16'h8000 | addr, rnd[23:16]);
		end
		close_download();
		for (n = 0; n < 64; n++) begin
			if (known[n]) check_read(15'(n), model[n]);
		end
		for (n = 0; n < 8; n++) begin
			raddr = FILL_BASE + 15'(n * 31);
			check_read(raddr, model[raddr]);
		end
		finish_test("oversize_loads");

		check_condition(i_dut.i_rom_assert.fail_count == 0, "a bound concurrent assertion failed");
		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- testbench/tb_arcade_rom_assert.sv
// Concurrent checks on the ROM subsystem top level, attached by bind.
// All properties are disabled while arst_n is low.
// fail_count holds the number of property failures seen so far.

`timescale 1ns/1ps

module tb_arcade_rom_assert import arcade_pkg::*; (
	input logic    clk_sys,
	input logic    arst_n,
	input logic    cpu_rd,
	input logic    game_reset,
	input logic    rom_valid,
	input logic    download_done,
	input ce_bus_t ce
);

	int fail_count = 0;

	// fixed fetch latency, checked both ways
	fetch_to_valid: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(cpu_rd && !game_reset) |-> ##2 rom_valid)
		else begin
			$error("rom_valid missing two cycles after an accepted fetch");
			fail_count++;
		end

	valid_from_fetch: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rom_valid |-> $past(cpu_rd && !game_reset, 2))
		else begin
			$error("rom_valid without an accepted fetch two cycles before");
			fail_count++;
		end

	done_one_cycle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		download_done |=> !download_done)
		else begin
			$error("download_done high for more than one cycle");
			fail_count++;
		end

	// the two 6 MHz phases never overlap
	ce6_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce.ce_6p && ce.ce_6n))
		else begin
			$error("ce_6p and ce_6n high together");
			fail_count++;
		end

endmodule

bind arcade_rom_top tb_arcade_rom_assert i_rom_assert (
	.clk_sys       (clk_sys),
	.arst_n        (arst_n),
	.cpu_rd        (cpu_rd),
	.game_reset    (game_reset),
	.rom_valid     (rom_valid),
	.download_done (download_done),
	.ce            (ce)
);

//--- design/arcade_rom_top.sv
// ROM download and program-fetch subsystem top level.
// ROM_ADDR_W sets the ROM size in bytes (2**ROM_ADDR_W, 15 at most).
// CE179_DIV sets the ce_1p79 period in clk_sys cycles.
// Fetches are refused while game_reset is high.

`timescale 1ns/1ps

module arcade_rom_top import arcade_pkg::*; #(
	parameter int ROM_ADDR_W = 15,
	parameter int CE179_DIV  = 14
) (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  user_reset,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  dl_byte_t              dl_byte,
	input  logic                  cpu_rd,
	input  logic [ROM_ADDR_W-1:0] cpu_addr,
	output logic [7:0]            rom_data,
	output logic                  rom_valid,
	output logic                  game_reset,
	output logic                  download_done,
	output ce_bus_t               ce
);

	rom_wr_t     rom_wr;
	rom_rd_t     rom_rd;
	logic [15:0] rd_word;

	ce_gen #(.CE179_DIV(CE179_DIV)) i_ce_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce      (ce)
	);

	// download side
	rom_loader #(.ROM_ADDR_W(ROM_ADDR_W)) i_rom_loader (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.user_reset    (user_reset),
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.dl_byte       (dl_byte),
		.rom_wr        (rom_wr),
		.game_reset    (game_reset),
		.download_done (download_done)
	);

	rom_store #(.ROM_ADDR_W(ROM_ADDR_W)) i_rom_store (
		.clk_sys (clk_sys),
		.rom_wr  (rom_wr),
		.rom_rd  (rom_rd),
		.rd_word (rd_word)
	);

	// CPU side
	rom_fetch #(.ROM_ADDR_W(ROM_ADDR_W)) i_rom_fetch (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.game_reset (game_reset),
		.cpu_rd     (cpu_rd),
		.cpu_addr   (cpu_addr),
		.rom_rd     (rom_rd),
		.rd_word    (rd_word),
		.rom_data   (rom_data),
		.rom_valid  (rom_valid)
	);

endmodule

//--- design/rom_fetch.sv
// CPU byte-fetch pipeline, fixed latency of 2 cycles.
// A fetch is accepted on any cycle where cpu_rd is high and game_reset is
// low; two fetches may be in flight. There is no back-pressure, so the
// CPU must take every rom_valid. rom_data is only meaningful with rom_valid.

`timescale 1ns/1ps

module rom_fetch import arcade_pkg::*; #(
	parameter int ROM_ADDR_W = 15
) (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  game_reset,
	input  logic                  cpu_rd,
	input  logic [ROM_ADDR_W-1:0] cpu_addr,
	output rom_rd_t               rom_rd,
	input  logic [15:0]           rd_word,
	output logic [7:0]            rom_data,
	output logic                  rom_valid
);

	fetch_stage_e            s1_tag;
	fetch_stage_e            s2_tag;
	logic [ROM_ADDR_W-2:0]   s1_addr;
	logic                    s1_lane;
	logic                    s2_lane;

	// ========================================================================
	// stage 1: accept and issue word read
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			s1_tag <= STG_EMPTY;
		end else if (cpu_rd && !game_reset) begin
			s1_tag <= STG_BUSY;
		end else begin
			s1_tag <= STG_EMPTY;
		end
	end

	always_ff @(posedge clk_sys) begin
		s1_addr <= cpu_addr[ROM_ADDR_W-1:1];
		s1_lane <= cpu_addr[0];
	end

	assign rom_rd = '{rd: (s1_tag == STG_BUSY), addr: 14'(s1_addr)};

	// ========================================================================
	// stage 2: lane select while the store returns the word
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			s2_tag <= STG_EMPTY;
		end else begin
			s2_tag <= s1_tag;
		end
	end

	always_ff @(posedge clk_sys) begin
		s2_lane <= s1_lane;
	end

	// odd byte address lives in the high lane
	assign rom_data  = s2_lane ? rd_word[15:8] : rd_word[7:0];
	assign rom_valid = (s2_tag == STG_BUSY);

endmodule

//--- design/rom_store.sv
// Word-wide ROM store, 2**(ROM_ADDR_W-1) words of 16 bits.
// Per-lane write enables; the read word is registered and appears the
// cycle after a read strobe. Contents are unknown until downloaded.
// A read of a word being written in the same cycle returns the old word.

`timescale 1ns/1ps

module rom_store import arcade_pkg::*; #(
	parameter int ROM_ADDR_W = 15
) (
	input  logic        clk_sys,
	input  rom_wr_t     rom_wr,
	input  rom_rd_t     rom_rd,
	output logic [15:0] rd_word
);

	localparam int WORD_W = ROM_ADDR_W - 1;
	localparam int WORDS  = 2 ** WORD_W;

	logic [15:0] mem [0:WORDS-1];

	// write port, one enable per byte lane
	always_ff @(posedge clk_sys) begin
		if (rom_wr.we) begin
			if (rom_wr.be[0]) begin
				mem[rom_wr.addr[WORD_W-1:0]][7:0] <= rom_wr.data[7:0];
			end
			if (rom_wr.be[1]) begin
				mem[rom_wr.addr[WORD_W-1:0]][15:8] <= rom_wr.data[15:8];
			end
		end
	end

	// registered read port
	always_ff @(posedge clk_sys) begin
		if (rom_rd.rd) begin
			rd_word <= mem[rom_rd.addr[WORD_W-1:0]];
		end
	end

endmodule

//--- design/rom_loader.sv
// Download loader. Each rising edge of dl_wr while dl_active is high
// becomes one word write with a single byte lane enabled.
// The write strobe is registered one cycle after the rising dl_wr is
// sampled, so the store writes two edges after that sample.
// Bytes at or above 2**ROM_ADDR_W are dropped. ROM_ADDR_W is 2 to 15.
// game_reset is combinational: high while user_reset or dl_active is high.

`timescale 1ns/1ps

module rom_loader import arcade_pkg::*; #(
	parameter int ROM_ADDR_W = 15
) (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     user_reset,
	input  logic     dl_active,
	input  logic     dl_wr,
	input  dl_byte_t dl_byte,
	output rom_wr_t  rom_wr,
	output logic     game_reset,
	output logic     download_done
);

	localparam logic [16:0] ROM_BYTES = 17'(1) << ROM_ADDR_W;

	load_state_e state;
	logic        wr_q;
	logic        wr_qq;
	dl_byte_t    byte_q;
	logic        wr_rise;
	logic        in_range;

	logic        wr_stb;
	logic [13:0] wr_addr;
	logic [15:0] wr_data;
	logic [1:0]  wr_be;

	// ========================================================================
	// input sampling and edge detect
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_q  <= 1'b0;
			wr_qq <= 1'b0;
		end else begin
			wr_q  <= dl_wr;
			wr_qq <= wr_q;
		end
	end

	// held stable by the host while dl_wr is high
	always_ff @(posedge clk_sys) begin
		byte_q <= dl_byte;
	end

	assign wr_rise  = wr_q & ~wr_qq;
	assign in_range = {1'b0, byte_q.addr} < ROM_BYTES;

	// ========================================================================
	// download state and done pulse
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state         <= ST_IDLE;
			download_done <= 1'b0;
		end else begin
			download_done <= 1'b0;
			case (state)
				ST_IDLE: if (dl_active) state <= ST_LOADING;
				ST_LOADING: begin
					if (!dl_active) begin
						state         <= ST_IDLE;
						download_done <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ========================================================================
	// word write
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_stb <= 1'b0;
		end else begin
			wr_stb <= wr_rise & in_range & (state == ST_LOADING);
		end
	end

	// byte goes to both lanes, address bit 0 picks the enabled one
	always_ff @(posedge clk_sys) begin
		wr_addr <= 14'(byte_q.addr[ROM_ADDR_W-1:1]);
		wr_data <= {byte_q.data, byte_q.data};
		wr_be   <= {byte_q.addr[0], ~byte_q.addr[0]};
	end

	assign rom_wr     = '{we: wr_stb, addr: wr_addr, data: wr_data, be: wr_be};
	assign game_reset = user_reset | dl_active;

endmodule

//--- design/ce_gen.sv
// Clock-enable generator for the board.
// ce_12 is high every second cycle; ce_6p and ce_6n are one cycle in four,
// on different phases. ce_1p79 is one cycle in CE179_DIV (at least 2).
// All enables are registered and low during reset.

`timescale 1ns/1ps

module ce_gen import arcade_pkg::*; #(
	parameter int CE179_DIV = 14
) (
	input  logic    clk_sys,
	input  logic    arst_n,
	output ce_bus_t ce
);

	localparam int DIV_W = $clog2(CE179_DIV);

	logic [1:0]       phase;
	logic [DIV_W-1:0] div179;

	// ========================================================================
	// 12 / 6 MHz phases
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase      <= 2'd0;
			ce.ce_12   <= 1'b0;
			ce.ce_6p   <= 1'b0;
			ce.ce_6n   <= 1'b0;
		end else begin
			phase      <= phase + 2'd1;
			ce.ce_12   <= phase[0];
			// the two 6 MHz phases sit half a period apart
			ce.ce_6p   <= phase[0] & ~phase[1];
			ce.ce_6n   <= phase[0] & phase[1];
		end
	end

	// ========================================================================
	// 1.79 MHz enable
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div179     <= DIV_W'(CE179_DIV - 1);
			ce.ce_1p79 <= 1'b0;
		end else if (div179 == '0) begin
			// reload and fire
			div179     <= DIV_W'(CE179_DIV - 1);
			ce.ce_1p79 <= 1'b1;
		end else begin
			div179     <= div179 - DIV_W'(1);
			ce.ce_1p79 <= 1'b0;
		end
	end

endmodule

//--- design/arcade_pkg.sv
// Shared types for the ROM download and program-fetch subsystem.
// Word addresses are 14 bits wide, so byte addresses up to 15 bits fit.
// Word data carries the download byte in both lanes, and the byte enables
// pick the lane that is written.

package arcade_pkg;

	// one byte from the download stream
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
	} dl_byte_t;

	// word write into the ROM store
	typedef struct packed {
		logic        we;
		logic [13:0] addr;
		logic [15:0] data;
		logic [1:0]  be;   // bit 0 low lane, bit 1 high lane
	} rom_wr_t;

	// word read from the ROM store
	typedef struct packed {
		logic        rd;
		logic [13:0] addr;
	} rom_rd_t;

	// board clock enables
	typedef struct packed {
		logic ce_12;
		logic ce_6p;
		logic ce_6n;
		logic ce_1p79;
	} ce_bus_t;

	typedef enum logic {ST_IDLE = 1'b0, ST_LOADING = 1'b1} load_state_e;

	typedef enum logic {STG_EMPTY = 1'b0, STG_BUSY = 1'b1} fetch_stage_e;

endpackage
